// File: logic/rv_isa_pkg.sv
`default_nettype none

// Encodings of the RV32I subset that the core executes.
// Only add, sub, and, or, addi, lw, sw and beq are decoded.
package rv_isa_pkg;

    // ------------------------------
    // major opcodes
    // ------------------------------

    // bits [6:0] of every supported instruction.
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        load   = 7'b0000011,
        store  = 7'b0100011,
        branch = 7'b1100011
    } opcode_e;

    // ------------------------------
    // funct fields
    // ------------------------------

    // funct3 is bits [14:12]. add and sub share a value and are told apart by funct7.
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_or      = 3'b110;
    // lw and sw both carry the word-size code.
    localparam logic [2:0] f3_word    = 3'b010;
    localparam logic [2:0] f3_beq     = 3'b000;

    // funct7 is bits [31:25]. only sub sets bit 30.
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    // ------------------------------
    // immediate formats and ALU operations
    // ------------------------------

    // selects which bit layout the immediate extender reassembles.
    typedef enum logic [1:0] {
        imm_i = 2'b00,
        imm_s = 2'b01,
        imm_b = 2'b10
    } imm_src_e;

    // the four ALU operations. add and sub share one adder.
    typedef enum logic [1:0] {
        alu_add = 2'b00,
        alu_sub = 2'b01,
        alu_and = 2'b10,
        alu_or  = 2'b11
    } alu_op_e;

endpackage

`default_nettype wire

// File: logic/rv_core_pkg.sv
`default_nettype none

// Microarchitectural types shared by the decoder, the datapath and the top level.
package rv_core_pkg;

    // ------------------------------
    // multiplexer selectors
    // ------------------------------

    // second ALU operand, register rs2 or the extended immediate.
    typedef enum logic {
        alu_src_reg = 1'b0,
        alu_src_imm = 1'b1
    } alu_src_e;

    // value written back to rd, ALU result or loaded word.
    typedef enum logic {
        res_src_alu = 1'b0,
        res_src_mem = 1'b1
    } result_src_e;

    // next pc, sequential or the branch target.
    typedef enum logic {
        pc_src_plus4  = 1'b0,
        pc_src_target = 1'b1
    } pc_src_e;

    // ------------------------------
    // control word and flags
    // ------------------------------

    // one control word per instruction, 9 bits wide.
    typedef struct packed {
        logic                 reg_we;
        logic                 mem_we;
        rv_isa_pkg::imm_src_e imm_src;
        rv_isa_pkg::alu_op_e  alu_op;
        alu_src_e             alu_src;
        result_src_e          result_src;
        pc_src_e              pc_src;
    } ctrl_t;

    // condition flags of the last ALU result.
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } alu_flags_t;

endpackage

`default_nettype wire

// File: logic/imm_extend.sv
`default_nettype none

// Rebuilds the 32-bit sign-extended immediate for the I, S and B formats.
module imm_extend (
    input  wire logic [31:0]          instr,
    input  wire rv_isa_pkg::imm_src_e imm_src,
    output logic [31:0]               imm
);

    logic [31:0] imm_i_val;
    logic [31:0] imm_s_val;
    logic [31:0] imm_b_val;

    // I format keeps its 12 bits contiguous at the top of the word.
    assign imm_i_val = {{20{instr[31]}}, instr[31:20]};

    // S format splits the immediate around the rd field.
    assign imm_s_val = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    // B format scrambles bits 12 and 11 and always has bit 0 cleared.
    // The offset is in bytes, so bit 0 of the target stays zero.
    assign imm_b_val = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        case (imm_src)
            rv_isa_pkg::imm_i: imm = imm_i_val;
            rv_isa_pkg::imm_s: imm = imm_s_val;
            rv_isa_pkg::imm_b: imm = imm_b_val;
            // the spare code gives zero so the datapath never sees X.
            default:           imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`default_nettype none

// Integer register file with 32 entries.
// Two combinational read ports and one write port on the rising edge.
module reg_file (
    input  wire logic        clk,
    input  wire logic [4:0]  rs1,
    input  wire logic [4:0]  rs2,
    input  wire logic [4:0]  rd,
    input  wire logic [31:0] wd,
    input  wire logic        we,
    output logic [31:0]      rd1,
    output logic [31:0]      rd2
);

    // entry 0 exists but is never written.
    logic [31:0] regs [32];

    // ------------------------------
    // write port
    // ------------------------------

    // writes to x0 are dropped here, so the array never holds a value for it.
    always_ff @(posedge clk) begin
        if (we && (rd != 5'd0)) begin
            regs[rd] <= wd;
        end
    end

    // ------------------------------
    // read ports
    // ------------------------------

    // x0 is forced to zero on read as well.
    // This covers the power-up content of entry 0, which is undefined.
    assign rd1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

// File: logic/alu.sv
`default_nettype none

// Four-operation ALU with N, Z, C and V flags.
module alu (
    input  wire logic [31:0]         a,
    input  wire logic [31:0]         b,
    input  wire rv_isa_pkg::alu_op_e op,
    output logic [31:0]              y,
    output rv_core_pkg::alu_flags_t  flags
);

    logic        is_sub;
    logic [31:0] b_eff;
    logic [32:0] sum;
    logic        is_arith;

    // subtract is a plus the inverted b plus one.
    assign is_sub = (op == rv_isa_pkg::alu_sub);
    assign b_eff  = is_sub ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, b_eff} + {32'd0, is_sub};

    // carry and overflow only mean something for the adder.
    assign is_arith = (op == rv_isa_pkg::alu_add) || is_sub;

    always_comb begin
        case (op)
            rv_isa_pkg::alu_add: y = sum[31:0];
            rv_isa_pkg::alu_sub: y = sum[31:0];
            rv_isa_pkg::alu_and: y = a & b;
            rv_isa_pkg::alu_or:  y = a | b;
            default:             y = '0;
        endcase
    end

    // ------------------------------
    // flags
    // ------------------------------

    // n and z follow the selected result.
    assign flags.n = y[31];
    assign flags.z = (y == 32'd0);

    // for subtract, c set means no borrow occurred.
    assign flags.c = is_arith & sum[32];

    // signed overflow: both adder inputs share a sign that the sum does not.
    assign flags.v = is_arith & (a[31] == b_eff[31]) & (sum[31] != a[31]);

endmodule

`default_nettype wire

// File: logic/main_decoder.sv
`default_nettype none

// Decodes one instruction into the control word of the single-cycle datapath.
module main_decoder (
    input  wire logic [31:0]            instr,
    input  wire rv_core_pkg::alu_flags_t flags,
    input  wire logic                   run,
    output rv_core_pkg::ctrl_t          ctrl
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    rv_core_pkg::ctrl_t dec;
    logic               is_beq;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // ------------------------------
    // static decode
    // ------------------------------

    // This block does not look at the flags.
    // The branch decision is added after it, so alu_op never depends on the ALU output.
    always_comb begin
        // the default word is a no-op that only advances pc by 4.
        dec            = '0;
        dec.imm_src    = rv_isa_pkg::imm_i;
        dec.alu_op     = rv_isa_pkg::alu_add;
        dec.alu_src    = rv_core_pkg::alu_src_reg;
        dec.result_src = rv_core_pkg::res_src_alu;
        dec.pc_src     = rv_core_pkg::pc_src_plus4;
        is_beq         = 1'b0;

        case (opcode)
            rv_isa_pkg::op: begin
                // R-type. an unsupported funct pair leaves reg_we low.
                if (funct3 == rv_isa_pkg::f3_add_sub && funct7 == rv_isa_pkg::f7_base) begin
                    dec.reg_we = 1'b1;
                    dec.alu_op = rv_isa_pkg::alu_add;
                end else if (funct3 == rv_isa_pkg::f3_add_sub && funct7 == rv_isa_pkg::f7_sub) begin
                    dec.reg_we = 1'b1;
                    dec.alu_op = rv_isa_pkg::alu_sub;
                end else if (funct3 == rv_isa_pkg::f3_and && funct7 == rv_isa_pkg::f7_base) begin
                    dec.reg_we = 1'b1;
                    dec.alu_op = rv_isa_pkg::alu_and;
                end else if (funct3 == rv_isa_pkg::f3_or && funct7 == rv_isa_pkg::f7_base) begin
                    dec.reg_we = 1'b1;
                    dec.alu_op = rv_isa_pkg::alu_or;
                end
            end
            rv_isa_pkg::op_imm: begin
                // addi only.
                dec.reg_we  = (funct3 == rv_isa_pkg::f3_add_sub);
                dec.alu_src = rv_core_pkg::alu_src_imm;
            end
            rv_isa_pkg::load: begin
                // lw adds the I immediate to rs1 and writes back the memory word.
                dec.reg_we     = (funct3 == rv_isa_pkg::f3_word);
                dec.alu_src    = rv_core_pkg::alu_src_imm;
                dec.result_src = rv_core_pkg::res_src_mem;
            end
            rv_isa_pkg::store: begin
                dec.mem_we  = (funct3 == rv_isa_pkg::f3_word);
                dec.imm_src = rv_isa_pkg::imm_s;
                dec.alu_src = rv_core_pkg::alu_src_imm;
            end
            rv_isa_pkg::branch: begin
                // beq compares by subtracting rs2 from rs1.
                dec.imm_src = rv_isa_pkg::imm_b;
                dec.alu_op  = rv_isa_pkg::alu_sub;
                is_beq      = (funct3 == rv_isa_pkg::f3_beq);
            end
            default: begin
                // unknown opcodes keep the no-op word.
            end
        endcase
    end

    // ------------------------------
    // branch decision and run gating
    // ------------------------------

    always_comb begin
        ctrl = dec;
        if (is_beq && flags.z) begin
            ctrl.pc_src = rv_core_pkg::pc_src_target;
        end
        // nothing is written until the datapath has left reset.
        if (!run) begin
            ctrl.reg_we = 1'b0;
            ctrl.mem_we = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/datapath.sv
`default_nettype none

// Architectural state and execution path of the single-cycle core.
// One instruction retires at every rising edge once run is set.
module datapath #(
    parameter logic [31:0] reset_pc = 32'd0
) (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic [31:0]         instr,
    input  wire rv_core_pkg::ctrl_t  ctrl,
    input  wire logic [31:0]         read_data,
    output logic [31:0]              pc,
    output logic                     run,
    output rv_core_pkg::alu_flags_t  flags,
    output logic [31:0]              alu_out,
    output logic [31:0]              write_data
);

    logic [31:0] pc_plus_4;
    logic [31:0] pc_target;
    logic [31:0] pc_next;
    logic [31:0] imm;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [31:0] result;

    // ------------------------------
    // program counter and run flag
    // ------------------------------

    assign pc_plus_4 = pc + 32'd4;
    assign pc_target = pc + imm;
    assign pc_next   = (ctrl.pc_src == rv_core_pkg::pc_src_target) ? pc_target : pc_plus_4;

    // run rises at the first edge after reset release.
    // The decoder uses it to gate writes in the cycle that is still settling.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    // pc holds reset_pc until run is set.
    // The instruction at reset_pc is then executed exactly once.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else if (run) begin
            pc <= pc_next;
        end
    end

    // ------------------------------
    // execution path
    // ------------------------------

    // rs1 is bits [19:15], rs2 is bits [24:20] and rd is bits [11:7].
    reg_file u_reg_file (
        .clk (clk),
        .rs1 (instr[19:15]),
        .rs2 (instr[24:20]),
        .rd  (instr[11:7]),
        .wd  (result),
        .we  (ctrl.reg_we),
        .rd1 (src_a),
        .rd2 (write_data)
    );

    imm_extend u_imm_extend (
        .instr   (instr),
        .imm_src (ctrl.imm_src),
        .imm     (imm)
    );

    // rs2 doubles as the store data, so operand b picks between it and the immediate.
    assign src_b = (ctrl.alu_src == rv_core_pkg::alu_src_imm) ? imm : write_data;

    alu u_alu (
        .a     (src_a),
        .b     (src_b),
        .op    (ctrl.alu_op),
        .y     (alu_out),
        .flags (flags)
    );

    // write-back value for rd.
    assign result = (ctrl.result_src == rv_core_pkg::res_src_mem) ? read_data : alu_out;

    // a misaligned branch offset or reset_pc would show up here.
    pc_aligned_a: assert property (
        @(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// File: logic/data_ram.sv
`default_nettype none

// Word-addressed data memory.
// Reads are combinational and writes take effect at the rising edge.
module data_ram #(
    parameter int dmem_words = 256
) (
    input  wire logic        clk,
    input  wire logic [31:0] addr,
    input  wire logic [31:0] wdata,
    input  wire logic        we,
    output logic [31:0]      rdata
);

    localparam int idx_w = (dmem_words > 1) ? $clog2(dmem_words) : 1;

    logic [31:0]      mem [dmem_words] = '{default: 32'd0};
    logic [idx_w-1:0] idx;

    // bits [1:0] select a byte and are ignored.
    // The word number wraps at the depth.
    assign idx = idx_w'(addr[31:2] % dmem_words);

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];

    // only word stores exist, so the address from the ALU must be aligned.
    store_aligned_a: assert property (
        @(posedge clk) we |-> (addr[1:0] == 2'b00)
    );

endmodule

`default_nettype wire

// File: logic/rv_core_top.sv
`default_nettype none

// Single-cycle RV32I core with its data memory.
// Instruction fetch is an external combinational port.
module rv_core_top #(
    parameter logic [31:0] reset_pc   = 32'd0,
    parameter int          dmem_words = 256
) (
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic [31:0] instr,
    output logic [31:0]      pc,
    output logic             mem_we,
    output logic [31:0]      mem_addr,
    output logic [31:0]      mem_wdata
);

    rv_core_pkg::ctrl_t      ctrl;
    rv_core_pkg::alu_flags_t flags;
    logic                    run;
    logic [31:0]             alu_out;
    logic [31:0]             write_data;
    logic [31:0]             read_data;

    main_decoder u_main_decoder (
        .instr (instr),
        .flags (flags),
        .run   (run),
        .ctrl  (ctrl)
    );

    datapath #(
        .reset_pc (reset_pc)
    ) u_datapath (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr      (instr),
        .ctrl       (ctrl),
        .read_data  (read_data),
        .pc         (pc),
        .run        (run),
        .flags      (flags),
        .alu_out    (alu_out),
        .write_data (write_data)
    );

    // the ALU result is the data address for both lw and sw.
    data_ram #(
        .dmem_words (dmem_words)
    ) u_data_ram (
        .clk   (clk),
        .addr  (alu_out),
        .wdata (write_data),
        .we    (ctrl.mem_we),
        .rdata (read_data)
    );

    // copy of the internal store, visible to the outside.
    assign mem_we    = ctrl.mem_we;
    assign mem_addr  = alu_out;
    assign mem_wdata = write_data;

endmodule

`default_nettype wire

// File: tb/rv_core_tb.sv
`default_nettype none

// Testbench for the single-cycle core.
// An architectural model runs beside the DUT and concurrent assertions compare the two.
module rv_core_tb;

    localparam int period       = 8;
    localparam int reset_cycles = 8;
    localparam int dmem_words   = 256;
    localparam int imem_words   = 64;
    localparam int loop_count   = 3;

    // store that the model expects from the instruction in flight.
    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;

    logic [31:0] imem [imem_words];
    int          n_words = 0;
    string       test_names [$];
    int          markers [$];
    string       test_name = "reset";
    int          errors = 0;
    bit          prog_ready = 1'b0;

    // ------------------------------
    // reference model state
    // ------------------------------

    logic [31:0] m_regs [32] = '{default: 32'd0};
    logic [31:0] m_mem [dmem_words] = '{default: 32'd0};
    logic [31:0] m_pc;
    logic        m_live;
    logic [31:0] m_next_pc;
    logic        m_reg_wr;
    logic [31:0] m_reg_val;
    store_t      m_store;

    always #(period / 2) clk = ~clk;

    rv_core_top #(
        .reset_pc   (32'd0),
        .dmem_words (dmem_words)
    ) UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .instr     (instr),
        .pc        (pc),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    // the instruction memory answers in the same cycle that pc asks.
    assign instr = imem[pc[$clog2(imem_words)+1:2]];

    // ------------------------------
    // assembler
    // ------------------------------

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::op};
    endfunction

    function automatic logic [31:0] addi_op(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, rv_isa_pkg::f3_add_sub, rd, rv_isa_pkg::op_imm};
    endfunction

    function automatic logic [31:0] lw_op(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, rv_isa_pkg::f3_word, rd, rv_isa_pkg::load};
    endfunction

    // the S format splits the offset around the rd slot.
    function automatic logic [31:0] sw_op(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, rv_isa_pkg::f3_word, imm[4:0], rv_isa_pkg::store};
    endfunction

    // offset is a 13-bit byte distance whose bit 0 is dropped.
    function automatic logic [31:0] beq_op(input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, rv_isa_pkg::f3_beq, off[4:1], off[11],
                rv_isa_pkg::branch};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[n_words] = word;
        n_words++;
    endtask

    // a section ends where the next instruction would be placed.
    task automatic close_section(input string name);
        test_names.push_back(name);
        markers.push_back(n_words * 4);
    endtask

    // ------------------------------
    // reference model
    // ------------------------------

    function automatic logic [31:0] i_imm(input logic [31:0] w);
        return {{20{w[31]}}, w[31:20]};
    endfunction

    function automatic logic [31:0] s_imm(input logic [31:0] w);
        return {{20{w[31]}}, w[31:25], w[11:7]};
    endfunction

    function automatic logic [31:0] b_imm(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic int word_index(input logic [31:0] a);
        return int'(a[31:2] % dmem_words);
    endfunction

    // what the instruction on the fetch port should do, from the ISA rules alone.
    always_comb begin
        logic [31:0] a;
        logic [31:0] b;
        a = (instr[19:15] == 5'd0) ? 32'd0 : m_regs[instr[19:15]];
        b = (instr[24:20] == 5'd0) ? 32'd0 : m_regs[instr[24:20]];
        m_next_pc = m_pc + 32'd4;
        m_reg_wr  = 1'b0;
        m_reg_val = 32'd0;
        m_store   = '0;
        case (instr[6:0])
            rv_isa_pkg::op: begin
                m_reg_wr = 1'b1;
                case ({instr[31:25], instr[14:12]})
                    {rv_isa_pkg::f7_base, rv_isa_pkg::f3_add_sub}: m_reg_val = a + b;
                    {rv_isa_pkg::f7_sub, rv_isa_pkg::f3_add_sub}:  m_reg_val = a - b;
                    {rv_isa_pkg::f7_base, rv_isa_pkg::f3_and}:     m_reg_val = a & b;
                    {rv_isa_pkg::f7_base, rv_isa_pkg::f3_or}:      m_reg_val = a | b;
                    default:                                       m_reg_wr  = 1'b0;
                endcase
            end
            rv_isa_pkg::op_imm: begin
                m_reg_wr  = (instr[14:12] == rv_isa_pkg::f3_add_sub);
                m_reg_val = a + i_imm(instr);
            end
            rv_isa_pkg::load: begin
                m_reg_wr  = (instr[14:12] == rv_isa_pkg::f3_word);
                m_reg_val = m_mem[word_index(a + i_imm(instr))];
            end
            rv_isa_pkg::store: begin
                m_store.we   = (instr[14:12] == rv_isa_pkg::f3_word);
                m_store.addr = a + s_imm(instr);
                m_store.data = b;
            end
            rv_isa_pkg::branch: begin
                if (instr[14:12] == rv_isa_pkg::f3_beq && a == b) begin
                    m_next_pc = m_pc + b_imm(instr);
                end
            end
            default: begin
                // anything else only advances pc.
            end
        endcase
        // nothing retires in the cycle right after reset release.
        if (!m_live) begin
            m_store.we = 1'b0;
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_live <= 1'b0;
            m_pc   <= 32'd0;
        end else begin
            m_live <= 1'b1;
            if (m_live) begin
                m_pc <= m_next_pc;
                if (m_reg_wr && instr[11:7] != 5'd0) begin
                    m_regs[instr[11:7]] <= m_reg_val;
                end
                if (m_store.we) begin
                    m_mem[word_index(m_store.addr)] <= m_store.data;
                end
            end
        end
    end

    // ------------------------------
    // checks
    // ------------------------------

    task automatic note_mismatch(input string what, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        errors++;
        $display("mismatch %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
    endtask

    reset_pc_a: assert property (@(posedge clk) !arst_n |-> pc == 32'd0)
        else note_mismatch("pc in reset", 32'd0, $sampled(pc));

    reset_store_a: assert property (@(posedge clk) !arst_n |-> !mem_we)
        else note_mismatch("mem_we in reset", 32'd0, 32'($sampled(mem_we)));

    pc_a: assert property (@(posedge clk) disable iff (!arst_n) pc == m_pc)
        else note_mismatch("pc", $sampled(m_pc), $sampled(pc));

    store_we_a: assert property (@(posedge clk) disable iff (!arst_n) mem_we == m_store.we)
        else note_mismatch("mem_we", 32'($sampled(m_store.we)), 32'($sampled(mem_we)));

    store_addr_a: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_we && m_store.we) |-> mem_addr == m_store.addr)
        else note_mismatch("mem_addr", $sampled(m_store.addr), $sampled(mem_addr));

    store_data_a: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_we && m_store.we) |-> mem_wdata == m_store.data)
        else note_mismatch("mem_wdata", $sampled(m_store.data), $sampled(mem_wdata));

    // ------------------------------
    // program and test flow
    // ------------------------------

    initial begin
        integer      seed;
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        int          start_err;
        int          failed;
        arst_n = 1'b0;
        seed   = 60491;
        failed = 0;
        // unused words hold an unknown opcode tagged with their own word address.
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = {25'(i), 7'h7f};
        end

        // a store at the reset vector. It sits on the fetch port through reset and the
        // first cycle after it, retires once, and then pc goes on to 4.
        emit(sw_op(5'd0, 5'd0, 12'd96));
        close_section("reset");

        // three rounds of random operands, each result stored to its own word.
        for (int k = 0; k < 3; k++) begin
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            emit(addi_op(5'd1, 5'd0, rnd_a[11:0]));
            emit(addi_op(5'd2, 5'd0, rnd_b[11:0]));
            emit(r_type(rv_isa_pkg::f7_base, rv_isa_pkg::f3_add_sub, 5'd3, 5'd1, 5'd2));
            emit(sw_op(5'd3, 5'd0, 12'(16 * k)));
            emit(r_type(rv_isa_pkg::f7_sub, rv_isa_pkg::f3_add_sub, 5'd4, 5'd1, 5'd2));
            emit(sw_op(5'd4, 5'd0, 12'(16 * k + 4)));
            emit(r_type(rv_isa_pkg::f7_base, rv_isa_pkg::f3_and, 5'd5, 5'd1, 5'd2));
            emit(sw_op(5'd5, 5'd0, 12'(16 * k + 8)));
            emit(r_type(rv_isa_pkg::f7_base, rv_isa_pkg::f3_or, 5'd6, 5'd1, 5'd2));
            emit(sw_op(5'd6, 5'd0, 12'(16 * k + 12)));
        end
        close_section("alu");

        // store, load back and store again at a second address.
        rnd_a = $random(seed);
        emit(addi_op(5'd8, 5'd0, rnd_a[11:0]));
        emit(sw_op(5'd8, 5'd0, 12'd64));
        emit(lw_op(5'd9, 5'd0, 12'd64));
        emit(sw_op(5'd9, 5'd0, 12'd68));
        // base 128 with offset -64 reaches the same word.
        emit(addi_op(5'd10, 5'd0, 12'd128));
        emit(lw_op(5'd11, 5'd10, 12'hfc0));
        emit(sw_op(5'd11, 5'd0, 12'd72));
        close_section("load");

        // counting loop. The forward beq exits, the backward one closes the loop.
        emit(addi_op(5'd5, 5'd0, 12'(loop_count)));
        emit(addi_op(5'd6, 5'd0, 12'd0));
        emit(addi_op(5'd6, 5'd6, 12'd1));
        emit(beq_op(5'd6, 5'd5, 13'd8));
        emit(beq_op(5'd0, 5'd0, 13'h1ff8));
        emit(sw_op(5'd6, 5'd0, 12'd80));
        // 3 against 0 must fall through to the store.
        emit(beq_op(5'd5, 5'd0, 13'd8));
        emit(sw_op(5'd5, 5'd0, 12'd84));
        close_section("branch");

        emit(addi_op(5'd0, 5'd0, 12'h5a5));
        emit(lw_op(5'd0, 5'd0, 12'd64));
        emit(sw_op(5'd0, 5'd0, 12'd88));
        close_section("x0");

        // an all-ones word, an all-zero word and a lui, none of them decoded.
        emit(32'hffff_ffff);
        emit(32'h0000_0000);
        emit({20'habcde, 5'd14, 7'b0110111});
        emit(addi_op(5'd13, 5'd0, 12'd1));
        emit(sw_op(5'd13, 5'd0, 12'd92));
        close_section("unknown");

        // the last marker is a branch to itself.
        emit(beq_op(5'd0, 5'd0, 13'd0));
        prog_ready = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;

        for (int t = 0; t < test_names.size(); t++) begin
            test_name = test_names[t];
            start_err = errors;
            do begin
                @(negedge clk);
            end while (pc !== markers[t]);
            if (errors == start_err) begin
                $display("test %-8s ok", test_name);
            end else begin
                failed++;
                $display("test %-8s %0d errors", test_name, errors - start_err);
            end
        end

        // let the checks of the last retired instructions finish.
        repeat (2) @(negedge clk);
        $display("tests run %0d, failed %0d, errors %0d", test_names.size(), failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // limit is twice the executed instruction count plus reset, in clock periods.
    initial begin
        time limit;
        wait (prog_ready);
        limit = (n_words + 3 * loop_count + reset_cycles + 4) * period * 2;
        #(limit);
        $display("watchdog: the program did not reach its last marker within %0t", limit);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_core.f
logic/rv_isa_pkg.sv
logic/rv_core_pkg.sv
logic/imm_extend.sv
logic/reg_file.sv
logic/alu.sv
logic/main_decoder.sv
logic/datapath.sv
logic/data_ram.sv
logic/rv_core_top.sv
tb/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - logic/rv_isa_pkg.sv
  - logic/rv_core_pkg.sv
  - logic/imm_extend.sv
  - logic/reg_file.sv
  - logic/alu.sv
  - logic/main_decoder.sv
  - logic/datapath.sv
  - logic/data_ram.sv
  - logic/rv_core_top.sv
  - target: test
    files:
      - tb/rv_core_tb.sv
